// File: tb.f
+incdir+logic
logic/datapath_pkg.sv
logic/registerFile.sv
logic/arithLogicUnit.sv
logic/memoryPort.sv
logic/instructionPath.sv
logic/ioPorts.sv
logic/controlSequencer.sv
logic/busDatapath.sv
verification/datapath_assert.sv
verification/datapath_tb.sv

// File: Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -f tb.f --top-module datapath_tb -Mdir obj_dir -o simv
	./obj_dir/simv > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "Test passed" $(LOG); then echo "Simulation did not finish"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

// File: verification/datapath_tb.sv
`include "datapath_settings.svh"

module datapath_tb;
        timeunit 1ns;
        timeprecision 100ps;

        import datapath_pkg::*;

        localparam int AddrWidth   = `MEM_ADDR_WIDTH;
        localparam int MemWords    = 2**`MEM_ADDR_WIDTH;
        localparam int DataBase    = 256;
        localparam int RandomOps   = 12;
        localparam int HaltTimeout = 3000;

        logic                   clk = 1'b0;
        logic                   reset;
        logic                   start;
        logic                   progWrite;
        logic [AddrWidth-1:0]   progAddr;
        logic [`DATA_WIDTH-1:0] progData;
        logic [`DATA_WIDTH-1:0] inPortData = '0;
        logic [`DATA_WIDTH-1:0] outPortData;
        logic                   outStrobe;
        logic                   halted;

        logic [`DATA_WIDTH-1:0] code[$];
        logic [`DATA_WIDTH-1:0] expectedQ[$];
        logic [`DATA_WIDTH-1:0] inValues [64];
        int                     inIndex = 0;

        always #4 clk = ~clk;

        busDatapath i_dut (
                .clk,
                .reset,
                .start,
                .progWrite,
                .progAddr,
                .progData,
                .inPortData,
                .outPortData,
                .outStrobe,
                .halted
        );

        bind controlSequencer datapath_assert i_sequencerChecks (
                .clk    (clk),
                .reset  (reset),
                .start  (start),
                .ctrl   (ctrl),
                .halted (halted)
        );

        task automatic stopWithFailure(string reason);
                $display("%s", reason);
                $display("Test failed");
                $fatal(1);
        endtask

        // Data region contents, a mix of the full address
        function automatic logic [31:0] dataFill(int addr);
                logic [31:0] a;
                a = 32'(addr);
                return (a * 32'h9E37_79B1) ^ {a[15:0], ~a[15:0]};
        endfunction

        function automatic logic [31:0] encode(opcodeT op, logic [3:0] ra, logic [3:0] rb,
                                               logic [18:0] low);
                return {op, ra, rb, low};
        endfunction

        function automatic logic [31:0] regOp(opcodeT op, logic [3:0] ra, logic [3:0] rb,
                                              logic [3:0] rc);
                return encode(op, ra, rb, {rc, 15'd0});
        endfunction

        function automatic opcodeT shiftOp();
                return opcodeT'(5'($urandom_range(int'(shr), int'(rol))));
        endfunction

        // r12 is a fixed base of 256, r13 to r15 hold shift amounts 0, 31 and above 31
        task automatic buildProgram();
                int         kind;
                logic [3:0] dst;
                logic [3:0] srcB;
                logic [3:0] srcC;
                for (int r = 0; r < 12; r++)
                        code.push_back(encode(ldi, 4'(r), 4'd0, 19'($urandom)));
                code.push_back(encode(ldi, 4'd12, 4'd0, 19'(DataBase)));
                code.push_back(encode(ldi, 4'd13, 4'd0, 19'd0));
                code.push_back(encode(ldi, 4'd14, 4'd0, 19'd31));
                code.push_back(encode(ldi, 4'd15, 4'd0, 19'($urandom_range(32, 300))));
                for (int i = 0; i < RandomOps; i++) begin
                        kind = $urandom_range(0, 7);
                        dst  = 4'($urandom_range(1, 11));
                        srcB = 4'($urandom_range(0, 15));
                        srcC = 4'($urandom_range(0, 15));
                        case (kind)
                                0: code.push_back(encode(ld, dst, 4'd0,
                                                         19'($urandom_range(256, 511))));
                                1: code.push_back(encode(ld, dst, 4'd12,
                                                         19'($urandom_range(0, 255))));
                                2: code.push_back(encode(st, srcC, 4'd12,
                                                         19'($urandom_range(0, 255))));
                                3: code.push_back(encode(inOp, dst, 4'd0, 19'd0));
                                4: code.push_back(regOp(shiftOp(), dst, srcB,
                                                        4'($urandom_range(13, 15))));
                                default: code.push_back(regOp(opcodeT'(5'($urandom_range(
                                        int'(add), int'(negOp)))), dst, srcB, srcC));
                        endcase
                        if (kind != 2)
                                code.push_back(encode(outOp, dst, 4'd0, 19'd0));
                end
                code.push_back(encode(inOp, 4'd1, 4'd0, 19'd0));
                code.push_back(encode(outOp, 4'd1, 4'd0, 19'd0));
                // Store through r12, read back at the same word through the r0 base
                code.push_back(encode(st, 4'($urandom_range(0, 15)), 4'd12, 19'd44));
                code.push_back(encode(ld, 4'd2, 4'd0, 19'd300));
                code.push_back(encode(outOp, 4'd2, 4'd0, 19'd0));
                for (int s = 13; s <= 15; s++) begin
                        code.push_back(regOp(shiftOp(), 4'd3, 4'($urandom_range(0, 11)), 4'(s)));
                        code.push_back(encode(outOp, 4'd3, 4'd0, 19'd0));
                end
                code.push_back(encode(halt, 4'd0, 4'd0, 19'd0));
        endtask

        // Instruction set interpreter, fills expectedQ with the output port values
        function automatic void runReference();
                logic [31:0] regs [16];
                logic [31:0] mem [MemWords];
                logic [31:0] word;
                logic [31:0] konst;
                logic [31:0] base;
                logic [31:0] y;
                logic [31:0] b;
                logic [8:0]  addr;
                logic [4:0]  amt;
                logic [3:0]  ra;
                opcodeT      op;
                int          outCount;
                outCount = 0;
                for (int r = 0; r < 16; r++)
                        regs[r] = '0;
                for (int a = 0; a < MemWords; a++)
                        mem[a] = (a < code.size()) ? code[a] : dataFill(a);
                foreach (code[pc]) begin
                        word  = code[pc];
                        op    = opcodeT'(word[31:27]);
                        ra    = word[26:23];
                        konst = {{13{word[18]}}, word[18:0]};
                        // r0 is zero only as an address base
                        base  = (word[22:19] == 4'd0) ? '0 : regs[word[22:19]];
                        addr  = 9'(base + konst);
                        y     = regs[word[22:19]];
                        b     = regs[word[18:15]];
                        amt   = b[4:0];
                        case (op)
                                ld:     regs[ra] = mem[addr];
                                ldi:    regs[ra] = base + konst;
                                st:     mem[addr] = regs[ra];
                                add:    regs[ra] = y + b;
                                sub:    regs[ra] = y - b;
                                andOp:  regs[ra] = y & b;
                                orOp:   regs[ra] = y | b;
                                xorOp:  regs[ra] = y ^ b;
                                norOp:  regs[ra] = ~(y | b);
                                notOp:  regs[ra] = ~b;
                                negOp:  regs[ra] = -b;
                                shr:    regs[ra] = y >> amt;
                                shl:    regs[ra] = y << amt;
                                shra:   regs[ra] = $signed(y) >>> amt;
                                ror:    regs[ra] = (y >> amt) | (y << (32 - amt));
                                rol:    regs[ra] = (y << amt) | (y >> (32 - amt));
                                inOp:   regs[ra] = inValues[outCount];
                                outOp: begin
                                        expectedQ.push_back(regs[ra]);
                                        outCount++;
                                end
                                default: ;
                        endcase
                end
        endfunction

        // Input port moves to its next value after each output
        always @(posedge clk) begin
                logic [31:0] expected;
                if (!reset && outStrobe) begin
                        assert (expectedQ.size() > 0)
                        else stopWithFailure("output strobe with no output left to expect");
                        expected = expectedQ.pop_front();
                        assert (outPortData == expected)
                        else begin
                                $display("CHECK FAILED outPortData: got %h, expected %h",
                                         outPortData, expected);
                                stopWithFailure("output port value mismatch");
                        end
                        inIndex = inIndex + 1;
                end
                inPortData <= inValues[inIndex];
        end

        initial begin
                void'($urandom(44));
                reset     = 1'b1;
                start     = 1'b0;
                progWrite = 1'b0;
                progAddr  = '0;
                progData  = '0;
                for (int i = 0; i < 64; i++)
                        inValues[i] = $urandom();
                buildProgram();
                runReference();
                repeat (3) @(posedge clk);
                reset <= 1'b0;
                for (int a = 0; a < MemWords; a++) begin
                        if (a < code.size() || a >= DataBase) begin
                                @(posedge clk);
                                progWrite <= 1'b1;
                                progAddr  <= AddrWidth'(a);
                                progData  <= (a < code.size()) ? code[a] : dataFill(a);
                        end
                end
                @(posedge clk);
                progWrite <= 1'b0;
                start     <= 1'b1;
                @(posedge clk);
                start <= 1'b0;
                for (int c = 0; c < HaltTimeout && !halted; c++)
                        @(posedge clk);
                assert (halted)
                else stopWithFailure("halted did not rise before the timeout");
                assert (expectedQ.size() == 0)
                else stopWithFailure($sformatf("halted with %0d outputs never seen",
                                               expectedQ.size()));
                // Quiet period to catch any stray output strobe
                for (int c = 0; c < 20; c++)
                        @(posedge clk);
                assert (i_dut.i_controlSequencer.i_sequencerChecks.failCount == 0)
                else stopWithFailure("a bound sequencer assertion failed");
                $display("Test passed");
                $finish;
        end

endmodule

// File: verification/datapath_assert.sv
module datapath_assert (
        input logic                      clk,
        input logic                      reset,
        input logic                      start,
        input datapath_pkg::controlWordT ctrl,
        input logic                      halted
);
        timeunit 1ns;
        timeprecision 100ps;

        logic [6:0] busSources;
        int         failCount = 0;

        assign busSources = {ctrl.rOut, ctrl.baOut, ctrl.zLowOut, ctrl.mdrOut,
                             ctrl.pcOut, ctrl.cOut, ctrl.inPortOut};

        // Shared bus takes one source at a time
        singleBusSource: assert property (@(posedge clk) $onehot0(busSources))
                else begin
                        $error("more than one bus source active");
                        failCount++;
                end

        // outPortIn is what raises outStrobe a cycle later
        quietInReset: assert property (@(posedge clk) reset |=> !halted && ctrl == '0)
                else begin
                        $error("strobes or halted active during reset");
                        failCount++;
                end

        quietAfterReset: assert property (@(posedge clk)
                $fell(reset) |=> !halted && !ctrl.outPortIn)
                else begin
                        $error("output port update or halted right after reset");
                        failCount++;
                end

        haltHolds: assert property (@(posedge clk) disable iff (reset)
                halted && !start |=> halted)
                else begin
                        $error("halted dropped without start");
                        failCount++;
                end

        // Sequencer stays idle while halted
        haltedIdle: assert property (@(posedge clk) halted |-> ctrl == '0)
                else begin
                        $error("control strobes active while halted");
                        failCount++;
                end

endmodule

// File: logic/busDatapath.sv
`include "datapath_settings.svh"

module busDatapath (
        input  logic                       clk,
        input  logic                       reset,
        input  logic                       start,
        input  logic                       progWrite,
        input  logic [`MEM_ADDR_WIDTH-1:0] progAddr,
        input  logic [`DATA_WIDTH-1:0]     progData,
        input  logic [`DATA_WIDTH-1:0]     inPortData,
        output logic [`DATA_WIDTH-1:0]     outPortData,
        output logic                       outStrobe,
        output logic                       halted
);
        import datapath_pkg::*;

        controlWordT            ctrl;
        instrFieldsT            instr;
        logic                   idle;
        logic [`DATA_WIDTH-1:0] busData;
        logic [`DATA_WIDTH-1:0] regData;
        logic [`DATA_WIDTH-1:0] zLow;
        logic [`DATA_WIDTH-1:0] mdrData;
        logic [`DATA_WIDTH-1:0] inPortValue;

        controlSequencer i_controlSequencer (
                .clk,
                .reset,
                .start,
                .instr,
                .ctrl,
                .halted,
                .idle
        );

        // start is dropped while an instruction runs
        instructionPath i_instructionPath (
                .clk,
                .reset,
                .ctrl,
                .start       (start && idle),
                .regData,
                .zLow,
                .mdrData,
                .inPortValue,
                .busData,
                .instr
        );

        registerFile i_registerFile (
                .clk,
                .reset,
                .ctrl,
                .instr,
                .busData,
                .regData
        );

        arithLogicUnit i_arithLogicUnit (
                .clk,
                .reset,
                .ctrl,
                .busData,
                .zLow
        );

        memoryPort i_memoryPort (
                .clk,
                .reset,
                .ctrl,
                .busData,
                .progWrite (progWrite && idle),
                .progAddr,
                .progData,
                .mdrData
        );

        ioPorts i_ioPorts (
                .clk,
                .reset,
                .ctrl,
                .busData,
                .inPortData,
                .inPortValue,
                .outPortData,
                .outStrobe
        );

endmodule

// File: logic/controlSequencer.sv
module controlSequencer (
        input  logic                      clk,
        input  logic                      reset,
        input  logic                      start,
        input  datapath_pkg::instrFieldsT instr,
        output datapath_pkg::controlWordT ctrl,
        output logic                      halted,
        output logic                      idle
);
        import datapath_pkg::*;

        logic       running;
        logic [2:0] step;
        logic       lastStep;
        logic       haltStep;

        always_comb begin
                ctrl     = '0;
                lastStep = 1'b0;
                haltStep = 1'b0;
                if (running && step < 3'd3) begin
                        // Fetch T0 to T2
                        ctrl.pcOut  = (step == 3'd0);
                        ctrl.marIn  = (step == 3'd0);
                        ctrl.incPc  = (step == 3'd0);
                        ctrl.read   = (step == 3'd1);
                        ctrl.mdrIn  = (step == 3'd1);
                        ctrl.mdrOut = (step == 3'd2);
                        ctrl.irIn   = (step == 3'd2);
                end else if (running) begin
                        case (instr.opcode)
                                ld, ldi, st: begin
                                        case (step)
                                                3'd3: begin
                                                        ctrl.grb   = 1'b1;
                                                        ctrl.baOut = 1'b1;
                                                        ctrl.yIn   = 1'b1;
                                                end
                                                3'd4: begin
                                                        ctrl.cOut  = 1'b1;
                                                        ctrl.zIn   = 1'b1;
                                                        ctrl.aluOp = add;
                                                end
                                                3'd5: begin
                                                        ctrl.zLowOut = 1'b1;
                                                        ctrl.gra     = (instr.opcode == ldi);
                                                        ctrl.rIn     = (instr.opcode == ldi);
                                                        ctrl.marIn   = (instr.opcode != ldi);
                                                        lastStep     = (instr.opcode == ldi);
                                                end
                                                3'd6: begin
                                                        // ld reads RAM, st puts Ra into MDR
                                                        ctrl.mdrIn = 1'b1;
                                                        ctrl.read  = (instr.opcode == ld);
                                                        ctrl.gra   = (instr.opcode == st);
                                                        ctrl.rOut  = (instr.opcode == st);
                                                end
                                                default: begin
                                                        ctrl.mdrOut = (instr.opcode == ld);
                                                        ctrl.gra    = (instr.opcode == ld);
                                                        ctrl.rIn    = (instr.opcode == ld);
                                                        ctrl.write  = (instr.opcode == st);
                                                        lastStep    = 1'b1;
                                                end
                                        endcase
                                end
                                add, sub, andOp, orOp, xorOp, norOp, notOp, negOp,
                                shr, shl, shra, ror, rol: begin
                                        case (step)
                                                3'd3: begin
                                                        ctrl.grb  = 1'b1;
                                                        ctrl.rOut = 1'b1;
                                                        ctrl.yIn  = 1'b1;
                                                end
                                                3'd4: begin
                                                        ctrl.grc   = 1'b1;
                                                        ctrl.rOut  = 1'b1;
                                                        ctrl.zIn   = 1'b1;
                                                        ctrl.aluOp = instr.opcode;
                                                end
                                                default: begin
                                                        ctrl.zLowOut = 1'b1;
                                                        ctrl.gra     = 1'b1;
                                                        ctrl.rIn     = 1'b1;
                                                        lastStep     = 1'b1;
                                                end
                                        endcase
                                end
                                inOp: begin
                                        ctrl.inPortOut = 1'b1;
                                        ctrl.gra       = 1'b1;
                                        ctrl.rIn       = 1'b1;
                                        lastStep       = 1'b1;
                                end
                                outOp: begin
                                        ctrl.gra       = 1'b1;
                                        ctrl.rOut      = 1'b1;
                                        ctrl.outPortIn = 1'b1;
                                        lastStep       = 1'b1;
                                end
                                // halt and unused encodings stop the machine
                                default: haltStep = 1'b1;
                        endcase
                end
        end

        always_ff @(posedge clk) begin
                if (reset) begin
                        running <= 1'b0;
                        step    <= '0;
                        halted  <= 1'b0;
                end else if (!running) begin
                        if (start) begin
                                running <= 1'b1;
                                step    <= '0;
                                halted  <= 1'b0;
                        end
                end else if (haltStep) begin
                        running <= 1'b0;
                        step    <= '0;
                        halted  <= 1'b1;
                end else if (lastStep) begin
                        step <= '0;
                end else begin
                        step <= step + 1'b1;
                end
        end

        assign idle = !running;

endmodule

// File: logic/ioPorts.sv
`include "datapath_settings.svh"

module ioPorts (
        input  logic                      clk,
        input  logic                      reset,
        input  datapath_pkg::controlWordT ctrl,
        input  logic [`DATA_WIDTH-1:0]    busData,
        input  logic [`DATA_WIDTH-1:0]    inPortData,
        output logic [`DATA_WIDTH-1:0]    inPortValue,
        output logic [`DATA_WIDTH-1:0]    outPortData,
        output logic                      outStrobe
);
        always_ff @(posedge clk) begin
                if (reset) begin
                        inPortValue <= '0;
                        outPortData <= '0;
                        outStrobe   <= 1'b0;
                end else begin
                        inPortValue <= inPortData;
                        if (ctrl.outPortIn)
                                outPortData <= busData;
                        // Strobe lines up with the new output value
                        outStrobe <= ctrl.outPortIn;
                end
        end

endmodule

// File: logic/instructionPath.sv
`include "datapath_settings.svh"

module instructionPath (
        input  logic                      clk,
        input  logic                      reset,
        input  datapath_pkg::controlWordT ctrl,
        input  logic                      start,
        input  logic [`DATA_WIDTH-1:0]    regData,
        input  logic [`DATA_WIDTH-1:0]    zLow,
        input  logic [`DATA_WIDTH-1:0]    mdrData,
        input  logic [`DATA_WIDTH-1:0]    inPortValue,
        output logic [`DATA_WIDTH-1:0]    busData,
        output datapath_pkg::instrFieldsT instr
);
        import datapath_pkg::*;

        localparam int ConstWidth = 19;

        logic [`DATA_WIDTH-1:0] pc;
        logic [`DATA_WIDTH-1:0] constExt;
        instrFieldsT            ir;

        always_ff @(posedge clk) begin
                if (reset || start)
                        pc <= '0;
                else if (ctrl.pcIn)
                        pc <= busData;
                else if (ctrl.incPc)
                        pc <= pc + 1'b1;
        end

        always_ff @(posedge clk) begin
                if (reset)
                        ir <= '0;
                else if (ctrl.irIn)
                        ir <= instrFieldsT'(busData);
        end

        assign constExt = {{(`DATA_WIDTH-ConstWidth){ir.low.constant[ConstWidth-1]}},
                           ir.low.constant};

        // Bus source mux, the sequencer asserts at most one out strobe
        always_comb begin
                if (ctrl.rOut || ctrl.baOut)
                        busData = regData;
                else if (ctrl.zLowOut)
                        busData = zLow;
                else if (ctrl.mdrOut)
                        busData = mdrData;
                else if (ctrl.pcOut)
                        busData = pc;
                else if (ctrl.cOut)
                        busData = constExt;
                else if (ctrl.inPortOut)
                        busData = inPortValue;
                else
                        busData = '0;
        end

        assign instr = ir;

endmodule

// File: logic/memoryPort.sv
`include "datapath_settings.svh"

module memoryPort (
        input  logic                        clk,
        input  logic                        reset,
        input  datapath_pkg::controlWordT   ctrl,
        input  logic [`DATA_WIDTH-1:0]      busData,
        input  logic                        progWrite,
        input  logic [`MEM_ADDR_WIDTH-1:0]  progAddr,
        input  logic [`DATA_WIDTH-1:0]      progData,
        output logic [`DATA_WIDTH-1:0]      mdrData
);
        logic [`DATA_WIDTH-1:0]     ram [2**`MEM_ADDR_WIDTH];
        logic [`MEM_ADDR_WIDTH-1:0] mar;
        logic [`DATA_WIDTH-1:0]     mdr;

        always_ff @(posedge clk) begin
                if (reset) begin
                        mar <= '0;
                        mdr <= '0;
                end else begin
                        // Only the low address bits reach the RAM
                        if (ctrl.marIn)
                                mar <= busData[`MEM_ADDR_WIDTH-1:0];
                        // read picks the RAM word, otherwise MDR takes the bus
                        if (ctrl.mdrIn)
                                mdr <= ctrl.read ? ram[mar] : busData;
                end
        end

        // Program load only happens while the sequencer is idle
        always_ff @(posedge clk) begin
                if (progWrite)
                        ram[progAddr] <= progData;
                else if (ctrl.write)
                        ram[mar] <= mdr;
        end

        assign mdrData = mdr;

endmodule

// File: logic/arithLogicUnit.sv
`include "datapath_settings.svh"

module arithLogicUnit (
        input  logic                      clk,
        input  logic                      reset,
        input  datapath_pkg::controlWordT ctrl,
        input  logic [`DATA_WIDTH-1:0]    busData,
        output logic [`DATA_WIDTH-1:0]    zLow
);
        import datapath_pkg::*;

        localparam int ShiftWidth = $clog2(`DATA_WIDTH);

        logic [`DATA_WIDTH-1:0]   y;
        logic [2*`DATA_WIDTH-1:0] z;
        logic [2*`DATA_WIDTH-1:0] result;
        logic [2*`DATA_WIDTH-1:0] rotRight;
        logic [2*`DATA_WIDTH-1:0] rotLeft;
        logic [ShiftWidth-1:0]    amount;

        // Shift amount is the bus value modulo the word width
        assign amount = busData[ShiftWidth-1:0];

        // Rotates shift a doubled copy of Y so the wrapped bits come back in
        assign rotRight = {y, y} >> amount;
        assign rotLeft  = {y, y} << amount;

        always_comb begin
                result = '0;
                case (ctrl.aluOp)
                        add:     result[`DATA_WIDTH-1:0] = y + busData;
                        sub:     result[`DATA_WIDTH-1:0] = y - busData;
                        andOp:   result[`DATA_WIDTH-1:0] = y & busData;
                        orOp:    result[`DATA_WIDTH-1:0] = y | busData;
                        xorOp:   result[`DATA_WIDTH-1:0] = y ^ busData;
                        norOp:   result[`DATA_WIDTH-1:0] = ~(y | busData);
                        // Unary ops work on the bus operand only
                        notOp:   result[`DATA_WIDTH-1:0] = ~busData;
                        negOp:   result[`DATA_WIDTH-1:0] = -busData;
                        shr:     result[`DATA_WIDTH-1:0] = y >> amount;
                        shl:     result[`DATA_WIDTH-1:0] = y << amount;
                        shra:    result[`DATA_WIDTH-1:0] = $signed(y) >>> amount;
                        ror:     result[`DATA_WIDTH-1:0] = rotRight[`DATA_WIDTH-1:0];
                        rol:     result[`DATA_WIDTH-1:0] = rotLeft[2*`DATA_WIDTH-1:`DATA_WIDTH];
                        default: result = '0;
                endcase
        end

        always_ff @(posedge clk) begin
                if (reset) begin
                        y <= '0;
                        z <= '0;
                end else begin
                        if (ctrl.yIn)
                                y <= busData;
                        if (ctrl.zIn)
                                z <= result;
                end
        end

        // High half of Z stays zero without mul and div
        assign zLow = z[`DATA_WIDTH-1:0];

endmodule

// File: logic/registerFile.sv
`include "datapath_settings.svh"

module registerFile (
        input  logic                      clk,
        input  logic                      reset,
        input  datapath_pkg::controlWordT ctrl,
        input  datapath_pkg::instrFieldsT instr,
        input  logic [`DATA_WIDTH-1:0]    busData,
        output logic [`DATA_WIDTH-1:0]    regData
);
        localparam int SelWidth = $clog2(`REG_COUNT);

        logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];
        logic [SelWidth-1:0]    sel;

        // Select and encode from the IR fields
        always_comb begin
                if (ctrl.gra)
                        sel = instr.ra;
                else if (ctrl.grb)
                        sel = instr.rb;
                else if (ctrl.grc)
                        sel = instr.low.regs.rc;
                else
                        sel = '0;
        end

        always_ff @(posedge clk) begin
                if (reset) begin
                        for (int i = 0; i < `REG_COUNT; i++)
                                regs[i] <= '0;
                end else if (ctrl.rIn) begin
                        regs[sel] <= busData;
                end
        end

        // r0 acts as a zero base for address arithmetic
        assign regData = (ctrl.baOut && sel == '0) ? '0 : regs[sel];

endmodule

// File: logic/datapath_pkg.sv
package datapath_pkg;

        // Encodings run from 0 in this order
        typedef enum logic [4:0] {
                ld, ldi, st,
                add, sub, andOp, orOp, xorOp, norOp, notOp, negOp,
                shr, shl, shra, ror, rol,
                inOp, outOp, halt
        } opcodeT;

        typedef struct packed {
                logic [3:0]  rc;
                logic [14:0] spare;
        } regFieldT;

        // Low 19 bits hold either rc or the constant
        typedef union packed {
                logic [18:0] constant;
                regFieldT    regs;
        } lowFieldT;

        typedef struct packed {
                opcodeT     opcode;
                logic [3:0] ra;
                logic [3:0] rb;
                lowFieldT   low;
        } instrFieldsT;

        typedef struct packed {
                logic   rIn;
                logic   rOut;
                logic   baOut;
                logic   gra;
                logic   grb;
                logic   grc;
                logic   marIn;
                logic   mdrIn;
                logic   mdrOut;
                logic   read;
                logic   write;
                logic   yIn;
                logic   zIn;
                logic   zLowOut;
                logic   pcIn;
                logic   pcOut;
                logic   incPc;
                logic   irIn;
                logic   cOut;
                logic   inPortOut;
                logic   outPortIn;
                opcodeT aluOp;
        } controlWordT;

endpackage

// File: logic/datapath_settings.svh
`ifndef DATAPATH_SETTINGS_SVH
`define DATAPATH_SETTINGS_SVH

// Word width of the bus, registers, ports and memory words
`define DATA_WIDTH 32

// General purpose registers r0 to r15
`define REG_COUNT 16

// 512 words of RAM
`define MEM_ADDR_WIDTH 9

`endif
